/* project.f */
src/roce_pkg.sv
src/roce_payload_shift.sv
src/roce_out_skid.sv
src/roce_hdr_ctrl.sv
src/roce_tx_top.sv
dv/tb_clk_gen.sv
dv/roce_tx_asserts.sv
dv/roce_tx_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the RoCE transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module roce_tx_tb -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }

/* dv/roce_tx_tb.sv */
`timescale 1ns/1ps

module roce_tx_tb;

  typedef struct packed {
    roce_pkg::hdr_kind_e kind;
    roce_pkg::bth_t      bth;
    roce_pkg::reth_t     reth;
    logic [15:0]         udp_len;
    logic [15:0]         nbytes;
    logic                rand_ready;
  } frame_row_t;

  localparam int n_rows = 6;

  logic clk;
  logic rst;
  logic s_hdr_valid;
  logic s_hdr_ready;
  roce_pkg::hdr_kind_e s_hdr_kind;
  roce_pkg::bth_t s_bth;
  roce_pkg::reth_t s_reth;
  roce_pkg::udp_hdr_t s_udp;
  roce_pkg::axis_word_t s_payload;
  logic s_payload_valid;
  logic s_payload_ready;
  logic m_hdr_valid;
  logic m_hdr_ready;
  roce_pkg::udp_hdr_t m_udp;
  logic [15:0] m_ip_length;
  roce_pkg::axis_word_t m_payload;
  logic m_payload_valid;
  logic m_payload_ready;
  logic busy;
  logic error_payload_early_termination;

  frame_row_t tbl [n_rows];
  integer seed = 32'h8714;
  logic [7:0] pl_bytes [$];
  logic [7:0] exp_bytes [$];
  roce_pkg::axis_word_t out_words [$];
  logic exp_user;
  logic rand_mode;
  logic got_last;
  logic busy_seen;
  int hdr_cnt;
  int err_cnt;
  int errors;
  int test_errors;
  int passed;
  int cycles;
  int limit;
  roce_pkg::udp_hdr_t hdr_seen;
  logic [15:0] ip_seen;

  tb_clk_gen u_clk (.clk(clk), .rst(rst));

  roce_tx_top uut (.*);

  bind roce_tx_top roce_tx_asserts u_asserts (.*);

  task automatic set_row(input int i, input roce_pkg::hdr_kind_e kind, input logic [7:0] op,
                         input logic [23:0] psn, input logic [15:0] udp_len,
                         input logic [15:0] nbytes, input logic rnd);
    tbl[i].kind = kind;
    tbl[i].bth = '{opcode: op, p_key: 16'hffff - 16'(i), psn: psn,
                   dest_qp: 24'h0a1b00 + 24'(i), ack_req: i[0]};
    tbl[i].reth = '{v_addr: 64'h0123_4567_89ab_cd00 + 64'(i), r_key: 32'hcafe_0100 + 32'(i),
                    dma_length: 32'h0000_1000 + 32'(i)};
    tbl[i].udp_len = udp_len;
    tbl[i].nbytes = nbytes;
    tbl[i].rand_ready = rnd;
  endtask

  function automatic int hdr_len(input roce_pkg::hdr_kind_e kind);
    return (kind == roce_pkg::hdr_bth) ? 12 : 28;
  endfunction

  function automatic roce_pkg::udp_hdr_t make_udp_hdr(input frame_row_t r);
    return '{src_port: 16'hc000, dst_port: 16'd4791, length: r.udp_len,
             checksum: 16'h1d00 ^ r.udp_len};
  endfunction

  // expected stream built from the byte layout rules
  task automatic build_expected(input frame_row_t r);
    int plen;
    exp_bytes.delete();
    exp_bytes.push_back(r.bth.opcode);
    exp_bytes.push_back(8'h00);
    exp_bytes.push_back(r.bth.p_key[15:8]);
    exp_bytes.push_back(r.bth.p_key[7:0]);
    exp_bytes.push_back(8'h00);
    for (int i = 2; i >= 0; i--) exp_bytes.push_back(r.bth.dest_qp[8*i +: 8]);
    exp_bytes.push_back({7'b0, r.bth.ack_req});
    for (int i = 2; i >= 0; i--) exp_bytes.push_back(r.bth.psn[8*i +: 8]);
    if (r.kind == roce_pkg::hdr_bth_reth) begin
      for (int i = 7; i >= 0; i--) exp_bytes.push_back(r.reth.v_addr[8*i +: 8]);
      for (int i = 3; i >= 0; i--) exp_bytes.push_back(r.reth.r_key[8*i +: 8]);
      for (int i = 3; i >= 0; i--) exp_bytes.push_back(r.reth.dma_length[8*i +: 8]);
    end
    plen = int'(r.udp_len) - 8 - hdr_len(r.kind) - 4;
    exp_user = (int'(r.nbytes) < plen);
    for (int i = 0; i < plen && i < int'(r.nbytes); i++) exp_bytes.push_back(pl_bytes[i]);
  endtask

  task automatic drive_header(input frame_row_t r);
    s_hdr_kind <= r.kind;
    s_bth <= r.bth;
    s_reth <= r.reth;
    s_udp <= make_udp_hdr(r);
    s_hdr_valid <= 1'b1;
    do @(posedge clk); while (!s_hdr_ready);
    s_hdr_valid <= 1'b0;
  endtask

  task automatic drive_payload(input int n);
    roce_pkg::axis_word_t w;
    for (int b = 0; b < n; b += 8) begin
      w = '0;
      for (int l = 0; l < 8 && b + l < n; l++) begin
        w.data[8*l +: 8] = pl_bytes[b + l];
        w.keep[l] = 1'b1;
      end
      w.last = (b + 8 >= n);
      s_payload <= w;
      s_payload_valid <= 1'b1;
      do @(posedge clk); while (!s_payload_ready);
    end
    s_payload_valid <= 1'b0;
  endtask

  task automatic check_frame(input frame_row_t r);
    logic [7:0] got [$];
    int nw;
    int tail;
    nw = out_words.size();
    tail = exp_bytes.size() - 8 * (nw - 1);
    for (int w = 0; w < nw; w++) begin
      for (int l = 0; l < 8; l++) begin
        if (out_words[w].keep[l]) got.push_back(out_words[w].data[8*l +: 8]);
      end
      assert (out_words[w].keep == ((w == nw - 1) ? 8'((1 << tail) - 1) : 8'hff)) else begin
        $display("Fail %0t: word %0d keep %h", $time, w, out_words[w].keep);
        test_errors++;
      end
      assert (out_words[w].last == (w == nw - 1)) else begin
        $display("Fail %0t: word %0d last flag %b", $time, w, out_words[w].last);
        test_errors++;
      end
    end
    assert (got.size() == exp_bytes.size()) else begin
      $display("Fail %0t: %0d bytes out, %0d expected", $time, got.size(), exp_bytes.size());
      test_errors++;
    end
    for (int i = 0; i < got.size() && i < exp_bytes.size(); i++) begin
      assert (got[i] == exp_bytes[i]) else begin
        $display("Fail %0t: byte %0d is %h, expected %h", $time, i, got[i], exp_bytes[i]);
        test_errors++;
      end
    end
    assert (out_words[nw - 1].user == exp_user && err_cnt == int'(exp_user)) else begin
      $display("Fail %0t: user %b with %0d error pulses", $time, out_words[nw - 1].user,
               err_cnt);
      test_errors++;
    end
    assert (hdr_cnt == 1 && hdr_seen == make_udp_hdr(r) && ip_seen == r.udp_len + 16'd20)
    else begin
      $display("Fail %0t: header out count %0d, udp %h, ip length %0d", $time, hdr_cnt,
               hdr_seen, ip_seen);
      test_errors++;
    end
    assert (busy_seen) else begin
      $display("Fail %0t: busy stayed low through the frame", $time);
      test_errors++;
    end
  endtask

  task automatic run_frame(input int t);
    frame_row_t r;
    r = tbl[t];
    pl_bytes.delete();
    for (int i = 0; i < int'(r.nbytes); i++) pl_bytes.push_back(8'($random(seed)));
    build_expected(r);
    out_words.delete();
    got_last = 1'b0;
    busy_seen = 1'b0;
    hdr_cnt = 0;
    err_cnt = 0;
    test_errors = 0;
    rand_mode = r.rand_ready;
    @(posedge clk);
    fork
      drive_header(r);
      drive_payload(int'(r.nbytes));
    join
    while (!(got_last && !busy && hdr_cnt > 0)) @(posedge clk);
    check_frame(r);
    errors += test_errors;
    if (test_errors == 0) passed++;
    $display("test %0d: %s", t, (test_errors == 0) ? "passed" : "failed");
  endtask

  // output side monitors
  always @(posedge clk) begin
    logic [31:0] r;
    r = $random(seed);
    m_payload_ready <= rand_mode ? r[0] : 1'b1;
    m_hdr_ready <= rand_mode ? r[1] : 1'b1;
    if (m_payload_valid && m_payload_ready) begin
      out_words.push_back(m_payload);
      if (m_payload.last) got_last = 1'b1;
    end
    if (m_hdr_valid && m_hdr_ready) begin
      hdr_cnt++;
      hdr_seen = m_udp;
      ip_seen = m_ip_length;
    end
    if (busy) busy_seen = 1'b1;
    if (error_payload_early_termination) err_cnt++;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles without the frame completing", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    s_hdr_valid = 1'b0;
    s_hdr_kind = roce_pkg::hdr_bth;
    s_bth = '0;
    s_reth = '0;
    s_udp = '0;
    s_payload = '0;
    s_payload_valid = 1'b0;
    m_hdr_ready = 1'b1;
    m_payload_ready = 1'b0;
    rand_mode = 1'b0;
    busy_seen = 1'b0;
    errors = 0;
    passed = 0;
    cycles = 0;
    // exact, reth, short, long, then stalled repeats
    set_row(0, roce_pkg::hdr_bth, 8'h04, 24'h000101, 16'd64, 16'd40, 1'b0);
    set_row(1, roce_pkg::hdr_bth_reth, 8'h0a, 24'h000202, 16'd77, 16'd37, 1'b0);
    set_row(2, roce_pkg::hdr_bth, 8'h04, 24'h000303, 16'd74, 16'd23, 1'b0);
    set_row(3, roce_pkg::hdr_bth_reth, 8'h0a, 24'h000404, 16'd60, 16'd35, 1'b0);
    set_row(4, roce_pkg::hdr_bth, 8'h04, 24'h000505, 16'd64, 16'd40, 1'b1);
    set_row(5, roce_pkg::hdr_bth_reth, 8'h0a, 24'h000606, 16'd77, 16'd37, 1'b1);
    limit = 5;
    for (int i = 0; i < n_rows; i++) begin
      limit += 4 * ((hdr_len(tbl[i].kind) + int'(tbl[i].nbytes) + 7) / 8 + 4);
    end
    while (rst) @(posedge clk);
    for (int t = 0; t < n_rows; t++) run_frame(t);
    $display("tests %0d, passed %0d, failed %0d, failed checks %0d", n_rows, passed,
             n_rows - passed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* dv/roce_tx_asserts.sv */
`timescale 1ns/1ps

module roce_tx_asserts (
  input logic                 clk,
  input logic                 rst,
  input logic                 s_hdr_ready,
  input logic                 s_payload_ready,
  input logic                 m_hdr_valid,
  input logic                 m_hdr_ready,
  input roce_pkg::axis_word_t m_payload,
  input logic                 m_payload_valid,
  input logic                 m_payload_ready,
  input logic                 busy,
  input logic                 error_payload_early_termination
);

  // stalled output words stay put
  a_payload_hold: assert property (@(posedge clk) disable iff (rst)
    m_payload_valid && !m_payload_ready |=> m_payload_valid && $stable(m_payload))
    else $error("payload valid dropped or data changed while stalled");

  a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
    m_hdr_valid && !m_hdr_ready |=> m_hdr_valid)
    else $error("header valid dropped before transfer");

  a_err_pulse: assert property (@(posedge clk) disable iff (rst)
    error_payload_early_termination |=> !error_payload_early_termination)
    else $error("early termination error longer than one cycle");

  a_err_user: assert property (@(posedge clk) disable iff (rst)
    error_payload_early_termination |-> m_payload_valid && m_payload.user)
    else $error("error pulse without a user flagged word");

  a_reset_quiet: assert property (@(posedge clk)
    $fell(rst) |-> !(s_hdr_ready || s_payload_ready || m_hdr_valid || m_payload_valid ||
                     busy || error_payload_early_termination))
    else $error("outputs active right after reset");

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held for five rising edges
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* src/roce_tx_top.sv */
`timescale 1ns/1ps

module roce_tx_top (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  s_hdr_valid,
  output logic                  s_hdr_ready,
  input  roce_pkg::hdr_kind_e   s_hdr_kind,
  input  roce_pkg::bth_t        s_bth,
  input  roce_pkg::reth_t       s_reth,
  input  roce_pkg::udp_hdr_t    s_udp,

  input  roce_pkg::axis_word_t  s_payload,
  input  logic                  s_payload_valid,
  output logic                  s_payload_ready,

  output logic                  m_hdr_valid,
  input  logic                  m_hdr_ready,
  output roce_pkg::udp_hdr_t    m_udp,
  output logic [15:0]           m_ip_length,

  output roce_pkg::axis_word_t  m_payload,
  output logic                  m_payload_valid,
  input  logic                  m_payload_ready,

  output logic                  busy,
  output logic                  error_payload_early_termination
);

  // realigned payload between shifter and controller
  roce_pkg::axis_word_t sh_word;
  logic sh_valid;
  logic sh_in_ready;
  logic sh_take;
  logic sh_flush;

  // controller to output skid
  roce_pkg::axis_word_t out_word;
  logic out_valid;
  logic out_ready_early;
  logic out_ready;

  roce_hdr_ctrl u_ctrl (
    .clk                             (clk),
    .rst                             (rst),
    .s_hdr_valid                     (s_hdr_valid),
    .s_hdr_ready                     (s_hdr_ready),
    .s_hdr_kind                      (s_hdr_kind),
    .s_bth                           (s_bth),
    .s_reth                          (s_reth),
    .s_udp                           (s_udp),
    .sh_word                         (sh_word),
    .sh_valid                        (sh_valid),
    .sh_in_ready                     (sh_in_ready),
    .sh_take                         (sh_take),
    .sh_flush                        (sh_flush),
    .s_payload_ready                 (s_payload_ready),
    .m_hdr_valid                     (m_hdr_valid),
    .m_hdr_ready                     (m_hdr_ready),
    .m_udp                           (m_udp),
    .m_ip_length                     (m_ip_length),
    .out_word                        (out_word),
    .out_valid                       (out_valid),
    .out_ready_early                 (out_ready_early),
    .out_ready                       (out_ready),
    .busy                            (busy),
    .error_payload_early_termination (error_payload_early_termination)
  );

  roce_payload_shift u_shift (
    .clk       (clk),
    .rst       (rst),
    .s_payload (s_payload),
    .s_valid   (s_payload_valid),
    .take      (sh_take),
    .flush     (sh_flush),
    .m_word    (sh_word),
    .m_valid   (sh_valid),
    .in_ready  (sh_in_ready)
  );

  roce_out_skid u_skid (
    .clk         (clk),
    .rst         (rst),
    .s_word      (out_word),
    .s_valid     (out_valid),
    .ready_early (out_ready_early),
    .ready       (out_ready),
    .m_word      (m_payload),
    .m_valid     (m_payload_valid),
    .m_ready     (m_payload_ready)
  );

endmodule

/* src/roce_hdr_ctrl.sv */
`timescale 1ns/1ps

module roce_hdr_ctrl (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  s_hdr_valid,
  output logic                  s_hdr_ready,
  input  roce_pkg::hdr_kind_e   s_hdr_kind,
  input  roce_pkg::bth_t        s_bth,
  input  roce_pkg::reth_t       s_reth,
  input  roce_pkg::udp_hdr_t    s_udp,

  input  roce_pkg::axis_word_t  sh_word,
  input  logic                  sh_valid,
  input  logic                  sh_in_ready,
  output logic                  sh_take,
  output logic                  sh_flush,

  output logic                  s_payload_ready,

  output logic                  m_hdr_valid,
  input  logic                  m_hdr_ready,
  output roce_pkg::udp_hdr_t    m_udp,
  output logic [15:0]           m_ip_length,

  output roce_pkg::axis_word_t  out_word,
  output logic                  out_valid,
  input  logic                  out_ready_early,
  input  logic                  out_ready,

  output logic                  busy,
  output logic                  error_payload_early_termination
);

  localparam int dw = roce_pkg::data_bytes * 8;
  localparam int half = roce_pkg::data_bytes / 2;
  localparam int img_bits = 4 * dw;
  // byte offset of the partial header word for each kind
  localparam logic [4:0] last_ptr_bth =
    5'((roce_pkg::bth_bytes / roce_pkg::data_bytes) * roce_pkg::data_bytes);
  localparam logic [4:0] last_ptr_reth =
    5'(((roce_pkg::bth_bytes + roce_pkg::reth_bytes) / roce_pkg::data_bytes) *
       roce_pkg::data_bytes);

  roce_pkg::tx_state_e state_q;
  roce_pkg::tx_state_e state_next;

  roce_pkg::hdr_kind_e kind_q;
  roce_pkg::bth_t      bth_q;
  roce_pkg::reth_t     reth_q;
  roce_pkg::udp_hdr_t  udp_q;
  logic [15:0]         ip_length_q;

  logic [4:0]  hdr_ptr_q;
  logic [4:0]  hdr_ptr_next;
  logic [15:0] remaining_q;
  logic [15:0] remaining_next;
  logic [15:0] hdr_len;

  logic [dw-1:0]                  last_data_q;
  logic [roce_pkg::data_bytes-1:0] last_keep_q;

  logic s_hdr_ready_q;
  logic s_payload_ready_q;
  logic s_payload_ready_next;
  logic hdr_valid_q;
  logic hdr_valid_next;
  logic busy_q;
  logic err_q;
  logic err_next;
  logic store_hdr;
  logic store_last;
  logic take;

  logic [img_bits-1:0] hdr_image;
  logic [dw-1:0]       hdr_word;
  logic [4:0]          last_ptr;

  roce_pkg::axis_word_t merged;
  roce_pkg::axis_word_t cand;
  logic [roce_pkg::cnt_w-1:0] cand_cnt;
  logic cand_done;
  logic word_in;

  // header bytes in lane order, multi-byte fields big endian
  always_comb begin
    hdr_image = '0;
    hdr_image[0 +: 8] = bth_q.opcode;
    hdr_image[16 +: 8] = bth_q.p_key[15:8];
    hdr_image[24 +: 8] = bth_q.p_key[7:0];
    for (int i = 0; i < 3; i++) begin
      hdr_image[8*(5+i) +: 8] = bth_q.dest_qp[8*(2-i) +: 8];
      hdr_image[8*(9+i) +: 8] = bth_q.psn[8*(2-i) +: 8];
    end
    hdr_image[64] = bth_q.ack_req;
    if (kind_q == roce_pkg::hdr_bth_reth) begin
      for (int i = 0; i < 8; i++) begin
        hdr_image[8*(12+i) +: 8] = reth_q.v_addr[8*(7-i) +: 8];
      end
      for (int i = 0; i < 4; i++) begin
        hdr_image[8*(20+i) +: 8] = reth_q.r_key[8*(3-i) +: 8];
        hdr_image[8*(24+i) +: 8] = reth_q.dma_length[8*(3-i) +: 8];
      end
    end
  end

  assign hdr_word = hdr_image[{hdr_ptr_q, 3'b000} +: dw];
  assign last_ptr = (kind_q == roce_pkg::hdr_bth) ? last_ptr_bth : last_ptr_reth;
  assign hdr_len = (s_hdr_kind == roce_pkg::hdr_bth) ?
                   16'(roce_pkg::bth_bytes) :
                   16'(roce_pkg::bth_bytes + roce_pkg::reth_bytes);

  // header tail in the low lanes, first shifted payload lanes above
  always_comb begin
    merged = sh_word;
    merged.data[half*8-1:0] = hdr_word[half*8-1:0];
    merged.keep[half-1:0] = '1;
  end

  assign cand = (state_q == roce_pkg::st_write_header_last) ? merged : sh_word;
  assign cand_cnt = roce_pkg::keep_to_count(cand.keep);
  assign cand_done = (16'(cand_cnt) >= remaining_q);
  assign word_in = sh_valid && out_ready;

  always_comb begin
    state_next = state_q;
    hdr_ptr_next = hdr_ptr_q;
    remaining_next = remaining_q;
    hdr_valid_next = hdr_valid_q && !m_hdr_ready;
    store_hdr = 1'b0;
    store_last = 1'b0;
    take = 1'b0;
    err_next = 1'b0;
    out_word = '0;
    out_valid = 1'b0;

    case (state_q)
      roce_pkg::st_idle: begin
        hdr_ptr_next = '0;
        if (s_hdr_valid && s_hdr_ready_q) begin
          store_hdr = 1'b1;
          hdr_valid_next = 1'b1;
          // bytes still owed from the partial header word onwards
          remaining_next = s_udp.length - hdr_len + 16'(half) -
                           16'(roce_pkg::udp_hdr_bytes + roce_pkg::icrc_bytes);
          state_next = roce_pkg::st_write_header;
        end
      end
      roce_pkg::st_write_header: begin
        if (out_ready) begin
          out_valid = 1'b1;
          out_word.data = hdr_word;
          out_word.keep = '1;
          hdr_ptr_next = hdr_ptr_q + 5'(roce_pkg::data_bytes);
          if (hdr_ptr_next == last_ptr) begin
            state_next = roce_pkg::st_write_header_last;
          end
        end
      end
      roce_pkg::st_write_header_last, roce_pkg::st_write_payload: begin
        if (word_in) begin
          take = 1'b1;
          out_word = cand;
          if (cand_done) begin
            out_word.keep = roce_pkg::count_to_keep(remaining_q[roce_pkg::cnt_w-1:0]);
            if (cand.last) begin
              out_valid = 1'b1;
              state_next = roce_pkg::st_idle;
            end else begin
              // trimmed word waits for the end of the input frame
              store_last = 1'b1;
              state_next = roce_pkg::st_write_payload_last;
            end
          end else begin
            out_valid = 1'b1;
            remaining_next = remaining_q - 16'(cand_cnt);
            if (cand.last) begin
              out_word.user = 1'b1;
              err_next = 1'b1;
              state_next = roce_pkg::st_idle;
            end else if (cand.user) begin
              // upstream marked the frame bad, close it and drop the rest
              out_word.last = 1'b1;
              state_next = roce_pkg::st_wait_last;
            end else begin
              state_next = roce_pkg::st_write_payload;
            end
          end
        end
      end
      roce_pkg::st_write_payload_last: begin
        out_word = '{data: last_data_q, keep: last_keep_q, last: 1'b1, user: sh_word.user};
        if (word_in) begin
          take = 1'b1;
          if (sh_word.last) begin
            out_valid = 1'b1;
            state_next = roce_pkg::st_idle;
          end
        end
      end
      roce_pkg::st_wait_last: begin
        if (sh_valid) begin
          take = 1'b1;
          if (sh_word.last) begin
            state_next = roce_pkg::st_idle;
          end
        end
      end
      default: begin
        state_next = roce_pkg::st_idle;
      end
    endcase
  end

  // input ready follows the state the FSM is moving into
  always_comb begin
    case (state_next)
      roce_pkg::st_write_header_last,
      roce_pkg::st_write_payload,
      roce_pkg::st_write_payload_last: s_payload_ready_next = out_ready_early && sh_in_ready;
      roce_pkg::st_wait_last:          s_payload_ready_next = sh_in_ready;
      default:                         s_payload_ready_next = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= roce_pkg::st_idle;
      hdr_ptr_q <= '0;
      remaining_q <= '0;
      s_hdr_ready_q <= 1'b0;
      s_payload_ready_q <= 1'b0;
      hdr_valid_q <= 1'b0;
      busy_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      state_q <= state_next;
      hdr_ptr_q <= hdr_ptr_next;
      remaining_q <= remaining_next;
      s_hdr_ready_q <= (state_next == roce_pkg::st_idle) && !hdr_valid_next;
      s_payload_ready_q <= s_payload_ready_next;
      hdr_valid_q <= hdr_valid_next;
      busy_q <= (state_next != roce_pkg::st_idle);
      err_q <= err_next;
    end
  end

  always_ff @(posedge clk) begin
    if (store_hdr) begin
      kind_q <= s_hdr_kind;
      bth_q <= s_bth;
      reth_q <= s_reth;
      udp_q <= s_udp;
      ip_length_q <= s_udp.length + 16'(roce_pkg::ip_hdr_bytes);
    end
    if (store_last) begin
      last_data_q <= out_word.data;
      last_keep_q <= out_word.keep;
    end
  end

  assign sh_take = take;
  assign sh_flush = (state_q == roce_pkg::st_idle);
  assign s_hdr_ready = s_hdr_ready_q;
  assign s_payload_ready = s_payload_ready_q;
  assign m_hdr_valid = hdr_valid_q;
  assign m_udp = udp_q;
  assign m_ip_length = ip_length_q;
  assign busy = busy_q;
  assign error_payload_early_termination = err_q;

endmodule

/* src/roce_out_skid.sv */
`timescale 1ns/1ps

module roce_out_skid (
  input  logic                 clk,
  input  logic                 rst,
  input  roce_pkg::axis_word_t s_word,
  input  logic                 s_valid,
  output logic                 ready_early,
  output logic                 ready,
  output roce_pkg::axis_word_t m_word,
  output logic                 m_valid,
  input  logic                 m_ready
);

  roce_pkg::axis_word_t out_q;
  roce_pkg::axis_word_t temp_q;

  logic out_valid_q;
  logic out_valid_next;
  logic temp_valid_q;
  logic temp_valid_next;
  logic ready_q;

  logic in_to_out;
  logic in_to_temp;
  logic temp_to_out;

  // room next cycle if the sink drains now or both stages are empty
  assign ready_early = m_ready || (!temp_valid_q && !out_valid_q);

  always_comb begin
    out_valid_next = out_valid_q;
    temp_valid_next = temp_valid_q;
    in_to_out = 1'b0;
    in_to_temp = 1'b0;
    temp_to_out = 1'b0;

    if (ready_q) begin
      if (m_ready || !out_valid_q) begin
        out_valid_next = s_valid;
        in_to_out = 1'b1;
      end else begin
        // sink stalled, park the incoming word
        temp_valid_next = s_valid;
        in_to_temp = 1'b1;
      end
    end else if (m_ready) begin
      out_valid_next = temp_valid_q;
      temp_valid_next = 1'b0;
      temp_to_out = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
      temp_valid_q <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      out_valid_q <= out_valid_next;
      temp_valid_q <= temp_valid_next;
      ready_q <= ready_early;
    end
  end

  always_ff @(posedge clk) begin
    if (in_to_out) begin
      out_q <= s_word;
    end else if (temp_to_out) begin
      out_q <= temp_q;
    end
    if (in_to_temp) begin
      temp_q <= s_word;
    end
  end

  assign ready = ready_q;
  assign m_word = out_q;
  assign m_valid = out_valid_q;

endmodule

/* src/roce_payload_shift.sv */
`timescale 1ns/1ps

module roce_payload_shift (
  input  logic                 clk,
  input  logic                 rst,
  input  roce_pkg::axis_word_t s_payload,
  input  logic                 s_valid,
  input  logic                 take,
  input  logic                 flush,
  output roce_pkg::axis_word_t m_word,
  output logic                 m_valid,
  output logic                 in_ready
);

  localparam int dw = roce_pkg::data_bytes * 8;
  localparam int half = roce_pkg::data_bytes / 2;

  logic [half*8-1:0]               save_data_q;
  logic [half-1:0]                 save_keep_q;
  logic                            save_user_q;
  // last input word of the frame has been consumed
  logic                            save_last_q;
  // saved upper lanes still owe one output word
  logic                            extra_q;
  logic                            upper_used;

  assign upper_used = |s_payload.keep[roce_pkg::data_bytes-1:half];

  always_comb begin
    m_word.data[half*8-1:0] = save_data_q;
    m_word.keep[half-1:0] = save_keep_q;
    if (extra_q) begin
      m_word.data[dw-1:half*8] = '0;
      m_word.keep[roce_pkg::data_bytes-1:half] = '0;
      m_word.last = 1'b1;
      m_word.user = save_user_q;
      m_valid = 1'b1;
    end else begin
      m_word.data[dw-1:half*8] = s_payload.data[half*8-1:0];
      m_word.keep[roce_pkg::data_bytes-1:half] = s_payload.keep[half-1:0];
      // last moves to the extra word when the upper lanes carry data
      m_word.last = s_payload.last && !upper_used;
      m_word.user = s_payload.user && !(s_payload.last && upper_used);
      m_valid = s_valid && !save_last_q;
    end
  end

  assign in_ready = !save_last_q && !(take && s_payload.last);

  always_ff @(posedge clk) begin
    if (rst) begin
      save_last_q <= 1'b0;
      extra_q <= 1'b0;
    end else if (flush) begin
      save_last_q <= 1'b0;
      extra_q <= 1'b0;
    end else if (take) begin
      if (!save_last_q) begin
        save_last_q <= s_payload.last;
        extra_q <= s_payload.last && upper_used;
      end else begin
        extra_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && !save_last_q) begin
      save_data_q <= s_payload.data[dw-1:half*8];
      save_keep_q <= s_payload.keep[roce_pkg::data_bytes-1:half];
      save_user_q <= s_payload.user;
    end
  end

endmodule

/* src/roce_pkg.sv */
package roce_pkg;

  // datapath geometry
  localparam int data_bytes = 8;
  localparam int cnt_w = $clog2(data_bytes + 1);

  // header and trailer sizes in bytes
  localparam int udp_hdr_bytes = 8;
  localparam int bth_bytes = 12;
  localparam int reth_bytes = 16;
  localparam int icrc_bytes = 4;
  localparam int ip_hdr_bytes = 20;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [15:0] p_key;
    logic [23:0] psn;
    logic [23:0] dest_qp;
    logic        ack_req;
  } bth_t;

  typedef struct packed {
    logic [63:0] v_addr;
    logic [31:0] r_key;
    logic [31:0] dma_length;
  } reth_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] checksum;
  } udp_hdr_t;

  // one beat of the byte-lane payload stream
  typedef struct packed {
    logic [data_bytes*8-1:0] data;
    logic [data_bytes-1:0]   keep;
    logic                    last;
    logic                    user;
  } axis_word_t;

  typedef enum logic [0:0] {
    hdr_bth,
    hdr_bth_reth
  } hdr_kind_e;

  typedef enum logic [2:0] {
    st_idle,
    st_write_header,
    st_write_header_last,
    st_write_payload,
    st_write_payload_last,
    st_wait_last
  } tx_state_e;

  // highest kept lane plus one, valid for contiguous masks
  function automatic logic [cnt_w-1:0] keep_to_count(input logic [data_bytes-1:0] keep);
    logic [cnt_w-1:0] n;
    n = '0;
    for (int i = 0; i < data_bytes; i++) begin
      if (keep[i]) begin
        n = cnt_w'(i + 1);
      end
    end
    return n;
  endfunction

  function automatic logic [data_bytes-1:0] count_to_keep(input logic [cnt_w-1:0] n);
    logic [data_bytes-1:0] k;
    for (int i = 0; i < data_bytes; i++) begin
      k[i] = (i < int'(n));
    end
    return k;
  endfunction

endpackage
